//--- verilog.f
+incdir+tb
verilog/cpu_cfg_pkg.sv
verilog/uop_pkg.sv
verilog/hds_pipe.sv
verilog/prf.sv
verilog/ro_stage.sv
verilog/alu_lane.sv
verilog/rr_top.sv
tb/tb_rr_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register-read slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module tb_rr_top -f verilog.f -o tb_rr_top > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_rr_top > sim.log 2>&1 || true
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; } \
   || { grep -q '\*\*\* PASSED \*\*\*' sim.log && exit 0 || exit 1; }

//--- tb/tb_rr_model.svh
//////////////////////////////
// Testbench reference model
// Register file, pending writes, xorshift, ALU rules
//////////////////////////////

`ifndef TB_RR_MODEL_SVH
`define TB_RR_MODEL_SVH

logic [data_w-1:0] ref_regs [prf_depth];   // Committed values only
logic [prf_depth-1:0] pending;             // Destinations still in flight
int readers [prf_depth];                   // Sources of micro-ops still in flight
logic [31:0] rng = 32'h6f94_1eb2;

function automatic logic [31:0] xorshift();
   rng = rng ^ (rng << 13);
   rng = rng ^ (rng >> 17);
   rng = rng ^ (rng << 5);
   return rng;
endfunction

// Reference ALU operations
function automatic logic [data_w-1:0] ref_alu(input alu_op_e op,
                                              input logic [data_w-1:0] x,
                                              input logic [data_w-1:0] y);
   int sh;
   sh = y % 32;   // Only the low 5 bits count
   case (op)
      alu_add: return x + y;
      alu_sub: return x + (~y) + 1;
      alu_and: return x & y;
      alu_or:  return x | y;
      alu_xor: return x ^ y;
      alu_sll: return x << sh;
      alu_srl: return x >> sh;
      default:
      begin
         // Signed compare through the sign bits
         if (x[data_w-1] != y[data_w-1])
            return (x[data_w-1]) ? 1 : 0;
         return (x < y) ? 1 : 0;
      end
   endcase
endfunction

// Result expected at write-back for an issued micro-op
function automatic wb_result_t expected_result(input issue_uop_t u);
   wb_result_t w;
   logic [data_w-1:0] x;
   logic [data_w-1:0] y;
   x = u.prs1_re ? ref_regs[u.prs1] : u.imm;
   y = u.prs2_re ? ref_regs[u.prs2] : u.imm;
   w.pc     = u.pc;
   w.result = ref_alu(u.alu_op, x, y);
   w.prd    = u.prd;
   w.prd_we = u.prd_we;
   w.rob_id = u.rob_id;
   return w;
endfunction

`endif

//--- tb/tb_rr_top.sv
//////////////////////////////
// Testbench of the register-read slice
// Issuer model, result checks, watchdog
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rr_top
   import cpu_cfg_pkg::*;
   import uop_pkg::*;
();

   localparam int clk_period  = 40;
   localparam int lat_edges   = 3;     // Acceptance edge to hand-off edge
   localparam int op_cnt      = 64 + 600 + 32;
   localparam int stall_bound = 4;     // Worst cycles per micro-op
   localparam int timeout_cyc = op_cnt * stall_bound + 300;

   logic                         clk = 1'b0;
   logic                         rst = 1'b1;
   logic                         flush = 1'b0;
   logic [lane_cnt-1:0]          issue_valid = '0;
   issue_uop_t [lane_cnt-1:0]    issue_uop = '0;
   logic [lane_cnt-1:0]          issue_ready;
   logic [lane_cnt-1:0]          wb_valid;
   wb_result_t [lane_cnt-1:0]    wb_result;
   logic [lane_cnt-1:0]          wb_ready = '0;

   `include "tb_rr_model.svh"

   wb_result_t exp_q [lane_cnt][$];
   issue_uop_t uop_q [lane_cnt][$];
   int         edge_q [lane_cnt][$];
   wb_result_t hold_exp [lane_cnt];
   issue_uop_t hold_uop [lane_cnt];
   logic [lane_cnt-1:0] taken = '0;    // Accepted at the coming edge
   int         edge_cnt = 0;
   int         err_cnt = 0;
   int         gen_mode = 0;           // 0 idle, 1 directed, 2 random, 3 readback
   logic       stall_en = 1'b0;
   logic       lat_check = 1'b0;
   logic       flush_req = 1'b0;
   int         dir_cnt [lane_cnt];
   int         rb_idx = 0;

   rr_top i_dut (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .issue_valid (issue_valid),
      .issue_uop   (issue_uop),
      .issue_ready (issue_ready),
      .wb_valid    (wb_valid),
      .wb_result   (wb_result),
      .wb_ready    (wb_ready)
   );

   always #(clk_period / 2) clk = ~clk;

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   task automatic value_error(input string msg);
      err_cnt++;
      $display("** Error at %0t ns: %s", $time, msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic run_error(input string msg);
      err_cnt++;
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   // Output goes quiet one edge after reset or flush
   assert property (@(posedge clk) (rst || flush) |=> (wb_valid == '0))
      else value_error("wb_valid high after reset or flush");

   // Next register with no write in flight
   function automatic preg_t free_src(input preg_t start);
      preg_t p;
      p = start;
      for (int i = 0; i < prf_depth; i++)
      begin
         if (!pending[p])
            return p;
         p = p + 1'b1;
      end
      return start;
   endfunction

   task automatic make_uop(input int l);
      issue_uop_t u;
      logic [31:0] r;
      u = '0;
      r = xorshift();
      u.pc = r[pc_w-1:0];
      r = xorshift();
      u.imm = r;
      r = xorshift();
      u.alu_op  = alu_op_e'(r[2:0]);
      u.prs1    = r[7:3];
      u.prs1_re = r[8];
      u.prs2    = r[13:9];
      u.prs2_re = r[14];
      u.prd     = r[19:15];
      u.prd_we  = (r[22:20] != 3'd0);
      u.rob_id  = r[26:23];
      if (gen_mode == 1)
      begin
         u.alu_op  = alu_op_e'(dir_cnt[l] % 8);
         u.prs1_re = dir_cnt[l][3];
         u.prs2_re = dir_cnt[l][4];
         dir_cnt[l]++;
      end
      else if (gen_mode == 3)
      begin
         u.alu_op  = alu_add;   // Register plus zero
         u.prs1    = rb_idx[prf_aw-1:0];
         u.prs1_re = 1'b1;
         u.prs2_re = 1'b0;
         u.imm     = '0;
         u.prd_we  = 1'b0;
         rb_idx++;
      end
      // Issuer keeps dependencies out of flight
      if (u.prs1_re && pending[u.prs1])
         u.prs1 = free_src(u.prs1);
      if (u.prs2_re && pending[u.prs2])
         u.prs2 = free_src(u.prs2);
      if (u.prd_we && (pending[u.prd] || readers[u.prd] != 0))
         u.prd_we = 1'b0;   // Other lane may not have read it yet
      if (u.prs1_re)
         readers[u.prs1]++;
      if (u.prs2_re)
         readers[u.prs2]++;
      if (u.prd_we)
         pending[u.prd] = 1'b1;
      hold_exp[l]    = expected_result(u);
      hold_uop[l]    = u;
      issue_uop[l]   = u;
      issue_valid[l] = 1'b1;
   endtask

   // One cycle: drive at the falling edge, then account for the coming edge
   task automatic cycle_step();
      wb_result_t  e;
      issue_uop_t  u;
      int          t;
      logic [31:0] r;
      logic        want;
      @(negedge clk);
      if (flush)
      begin
         for (int l = 0; l < lane_cnt; l++)
         begin
            exp_q[l].delete();
            uop_q[l].delete();
            edge_q[l].delete();
         end
         for (int p = 0; p < prf_depth; p++)
            readers[p] = 0;
         pending = '0;
         flush   = 1'b0;
      end
      for (int l = 0; l < lane_cnt; l++)
      begin
         if (taken[l])
            issue_valid[l] = 1'b0;
      end
      taken = '0;
      if (flush_req)
      begin
         flush       = 1'b1;
         flush_req   = 1'b0;
         issue_valid = '0;
      end
      else
      begin
         for (int l = 0; l < lane_cnt; l++)
         begin
            r = xorshift();
            case (gen_mode)
               1:       want = (dir_cnt[l] < 32);
               2:       want = (r[1:0] != 2'd0);
               3:       want = (l == 0) && (rb_idx < prf_depth);
               default: want = 1'b0;
            endcase
            if (want && !issue_valid[l])
               make_uop(l);
         end
      end
      for (int l = 0; l < lane_cnt; l++)
      begin
         r = xorshift();
         wb_ready[l] = stall_en ? (r[1:0] != 2'd0) : 1'b1;
      end
      // Handshakes are settled here until the rising edge
      #(clk_period / 4);
      if (!flush)
      begin
         for (int l = 0; l < lane_cnt; l++)
         begin
            if (exp_q[l].size() == 0)
            begin
               assert (!wb_valid[l])
                  else value_error($sformatf("lane %0d result with nothing in flight", l));
            end
            if (wb_valid[l] && wb_ready[l] && exp_q[l].size() != 0)
            begin
               e = exp_q[l].pop_front();
               u = uop_q[l].pop_front();
               t = edge_q[l].pop_front();
               assert (wb_result[l] == e)
                  else value_error($sformatf("lane %0d got %h expected %h",
                                             l, wb_result[l], e));
               if (lat_check)
               begin
                  assert (edge_cnt + 1 - t == lat_edges)
                     else value_error($sformatf("lane %0d latency %0d edges",
                                                l, edge_cnt + 1 - t));
               end
               if (e.prd_we)
               begin
                  ref_regs[e.prd] = e.result;
                  pending[e.prd]  = 1'b0;
               end
               if (u.prs1_re)
                  readers[u.prs1]--;
               if (u.prs2_re)
                  readers[u.prs2]--;
            end
         end
         for (int l = 0; l < lane_cnt; l++)
         begin
            if (issue_valid[l] && issue_ready[l])
            begin
               exp_q[l].push_back(hold_exp[l]);
               uop_q[l].push_back(hold_uop[l]);
               edge_q[l].push_back(edge_cnt + 1);
               taken[l] = 1'b1;
            end
         end
      end
   endtask

   task automatic drain();
      gen_mode = 0;
      stall_en = 1'b0;
      while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || issue_valid != '0)
         cycle_step();
   endtask

   initial
   begin
      #(timeout_cyc * clk_period);
      run_error("Timeout, results stopped arriving");
   end

   initial
   begin
      for (int r = 0; r < prf_depth; r++)
      begin
         ref_regs[r] = '0;
         readers[r]  = 0;
      end
      pending = '0;
      for (int l = 0; l < lane_cnt; l++)
         dir_cnt[l] = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Idle output after reset
      repeat (10) cycle_step();
      // Every op and operand source per lane, no stalls
      gen_mode  = 1;
      lat_check = 1'b1;
      while (dir_cnt[0] < 32 || dir_cnt[1] < 32)
         cycle_step();
      drain();
      lat_check = 1'b0;
      // Random traffic under back-pressure, flush midway
      gen_mode = 2;
      stall_en = 1'b1;
      repeat (300) cycle_step();
      flush_req = 1'b1;
      repeat (300) cycle_step();
      drain();
      // Read every register back
      gen_mode = 3;
      while (rb_idx < prf_depth)
         cycle_step();
      drain();
      repeat (5) cycle_step();
      if (err_cnt != 0)
      begin
         $display("*** FAILED ***");
         $fatal(1);
      end
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule : tb_rr_top

`default_nettype wire

//--- verilog/rr_top.sv
//////////////////////////////
// Register-read slice
// Input registers, read stage, PRF and ALU lanes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rr_top
   import cpu_cfg_pkg::*;
   import uop_pkg::*;
(
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            flush,
   // Issue side
   input  wire [lane_cnt-1:0]             issue_valid,
   input  issue_uop_t [lane_cnt-1:0]      issue_uop,
   output logic [lane_cnt-1:0]            issue_ready,
   // Write-back side
   output logic [lane_cnt-1:0]            wb_valid,
   output wb_result_t [lane_cnt-1:0]      wb_result,
   input  wire [lane_cnt-1:0]             wb_ready
);

   // Input register to read stage
   logic [lane_cnt-1:0]                   ir_valid;
   logic [lane_cnt-1:0]                   ir_ready;
   issue_uop_t [lane_cnt-1:0]             ir_uop;

   // Read stage to ALU
   logic [lane_cnt-1:0]                   ex_valid;
   logic [lane_cnt-1:0]                   ex_ready;
   ex_uop_t [lane_cnt-1:0]                ex_uop;

   // PRF ports
   logic [rd_port_cnt-1:0]                rd_en;
   logic [rd_port_cnt-1:0][prf_aw-1:0]    rd_addr;
   logic [rd_port_cnt-1:0][data_w-1:0]    rd_data;
   logic [lane_cnt-1:0]                   wr_en;
   logic [lane_cnt-1:0][prf_aw-1:0]       wr_addr;
   logic [lane_cnt-1:0][data_w-1:0]       wr_data;

   for (genvar i = 0; i < lane_cnt; i++)
   begin : gen_lane
      hds_pipe #(
         .payload_t (issue_uop_t)
      ) u_in (
         .clk       (clk),
         .rst       (rst),
         .flush     (flush),
         .in_valid  (issue_valid[i]),
         .in_data   (issue_uop[i]),
         .in_ready  (issue_ready[i]),
         .out_valid (ir_valid[i]),
         .out_data  (ir_uop[i]),
         .out_ready (ir_ready[i]),
         .load      ()
      );

      ro_stage u_ro (
         .clk       (clk),
         .rst       (rst),
         .flush     (flush),
         .in_valid  (ir_valid[i]),
         .in_uop    (ir_uop[i]),
         .in_ready  (ir_ready[i]),
         .prf_re    (rd_en[i*src_cnt +: src_cnt]),
         .prf_raddr (rd_addr[i*src_cnt +: src_cnt]),
         .prf_rdata (rd_data[i*src_cnt +: src_cnt]),
         .out_valid (ex_valid[i]),
         .out_uop   (ex_uop[i]),
         .out_ready (ex_ready[i])
      );

      alu_lane u_alu (
         .clk        (clk),
         .rst        (rst),
         .flush      (flush),
         .in_valid   (ex_valid[i]),
         .in_uop     (ex_uop[i]),
         .in_ready   (ex_ready[i]),
         .out_valid  (wb_valid[i]),
         .out_result (wb_result[i]),
         .out_ready  (wb_ready[i]),
         .wr_en      (wr_en[i]),
         .wr_addr    (wr_addr[i]),
         .wr_data    (wr_data[i])
      );
   end

   prf u_prf (
      .clk     (clk),
      .rst     (rst),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

endmodule : rr_top

`default_nettype wire

//--- verilog/alu_lane.sv
//////////////////////////////
// ALU lane
// Single-cycle integer ops, result register, PRF write
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu_lane
   import cpu_cfg_pkg::*;
   import uop_pkg::*;
(
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 flush,
   input  wire                 in_valid,
   input  ex_uop_t             in_uop,
   output logic                in_ready,
   output logic                out_valid,
   output wb_result_t          out_result,
   input  wire                 out_ready,
   // Write-back port of the PRF
   output logic                wr_en,
   output logic [prf_aw-1:0]   wr_addr,
   output logic [data_w-1:0]   wr_data
);

   data_t             a;
   data_t             b;
   logic [shamt_w-1:0] shamt;
   data_t             alu_res;
   wb_result_t        res_d;

   assign a     = in_uop.operand1;
   assign b     = in_uop.operand2;
   assign shamt = b[shamt_w-1:0];

   always_comb
   begin
      case (in_uop.alu_op)
         alu_add: alu_res = a + b;
         alu_sub: alu_res = a - b;
         alu_and: alu_res = a & b;
         alu_or:  alu_res = a | b;
         alu_xor: alu_res = a ^ b;
         alu_sll: alu_res = a << shamt;
         alu_srl: alu_res = a >> shamt;
         alu_slt: alu_res = {{(data_w-1){1'b0}}, ($signed(a) < $signed(b))};
         default: alu_res = '0;
      endcase
   end

   always_comb
   begin
      res_d.pc     = in_uop.pc;
      res_d.result = alu_res;
      res_d.prd    = in_uop.prd;
      res_d.prd_we = in_uop.prd_we;
      res_d.rob_id = in_uop.rob_id;
   end

   hds_pipe #(
      .payload_t (wb_result_t)
   ) u_out (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .in_valid  (in_valid),
      .in_data   (res_d),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_result),
      .out_ready (out_ready),
      .load      ()
   );

   // Commit to the PRF as the result is handed off
   assign wr_en   = out_valid & out_ready & out_result.prd_we & ~flush;
   assign wr_addr = out_result.prd;
   assign wr_data = out_result.result;

endmodule : alu_lane

`default_nettype wire

//--- verilog/ro_stage.sv
//////////////////////////////
// Register-read stage
// PRF reads and operand select for one lane
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ro_stage
   import cpu_cfg_pkg::*;
   import uop_pkg::*;
(
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 flush,
   // From the input register
   input  wire                                 in_valid,
   input  issue_uop_t                          in_uop,
   output logic                                in_ready,
   // To PRF
   output logic [src_cnt-1:0]                  prf_re,
   output logic [src_cnt-1:0][prf_aw-1:0]      prf_raddr,
   // From PRF, one cycle after the read
   input  wire [src_cnt-1:0][data_w-1:0]       prf_rdata,
   // To the ALU
   output logic                                out_valid,
   output ex_uop_t                             out_uop,
   input  wire                                 out_ready
);

   issue_uop_t s1_uop;   // Held micro-op
   logic       p_ce;
   data_t      operand1;
   data_t      operand2;

   hds_pipe #(
      .payload_t (issue_uop_t)
   ) u_buf (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .in_valid  (in_valid),
      .in_data   (in_uop),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (s1_uop),
      .out_ready (out_ready),
      .load      (p_ce)
   );

   // The PRF acts as the data half of this stage,
   // so read exactly on the edge the micro-op is captured
   assign prf_re[0]    = p_ce & in_uop.prs1_re;
   assign prf_re[1]    = p_ce & in_uop.prs2_re;
   assign prf_raddr[0] = in_uop.prs1;
   assign prf_raddr[1] = in_uop.prs2;

   // Register value or immediate
   assign operand1 = s1_uop.prs1_re ? prf_rdata[0] : s1_uop.imm;
   assign operand2 = s1_uop.prs2_re ? prf_rdata[1] : s1_uop.imm;

   always_comb
   begin
      out_uop.pc       = s1_uop.pc;
      out_uop.alu_op   = s1_uop.alu_op;
      out_uop.operand1 = operand1;
      out_uop.operand2 = operand2;
      out_uop.prd      = s1_uop.prd;
      out_uop.prd_we   = s1_uop.prd_we;
      out_uop.rob_id   = s1_uop.rob_id;   // Passed through only
   end

endmodule : ro_stage

`default_nettype wire

//--- verilog/prf.sv
//////////////////////////////
// Physical register file
// Two read ports and one write port per lane
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prf
   import cpu_cfg_pkg::*;
(
   input  wire                                     clk,
   input  wire                                     rst,
   input  wire [rd_port_cnt-1:0]                   rd_en,
   input  wire [rd_port_cnt-1:0][prf_aw-1:0]       rd_addr,
   output logic [rd_port_cnt-1:0][data_w-1:0]      rd_data,
   input  wire [lane_cnt-1:0]                      wr_en,
   input  wire [lane_cnt-1:0][prf_aw-1:0]          wr_addr,
   input  wire [lane_cnt-1:0][data_w-1:0]          wr_data
);

   logic [data_w-1:0] regs [prf_depth];

   // Higher lane index is written last and wins a clash
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int r = 0; r < prf_depth; r++)
            regs[r] <= '0;
      end
      else
      begin
         for (int l = 0; l < lane_cnt; l++)
         begin
            if (wr_en[l])
               regs[wr_addr[l]] <= wr_data[l];
         end
      end
   end

   // Registered read, held while the port is idle
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < rd_port_cnt; p++)
      begin
         if (rd_en[p])
         begin
            rd_data[p] <= regs[rd_addr[p]];
            // Write-first, same lane priority as the array
            for (int l = 0; l < lane_cnt; l++)
            begin
               if (wr_en[l] && (wr_addr[l] == rd_addr[p]))
                  rd_data[p] <= wr_data[l];
            end
         end
      end
   end

endmodule : prf

`default_nettype wire

//--- verilog/hds_pipe.sv
//////////////////////////////
// Handshake pipeline register
// One entry, valid/ready, flushable
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hds_pipe
   import cpu_cfg_pkg::*;
#(
   parameter type payload_t = logic [data_w-1:0]
)
(
   input  wire      clk,
   input  wire      rst,
   input  wire      flush,
   input  wire      in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  wire      out_ready,
   output logic     load
);

   logic     valid_q;
   payload_t data_q;

   // Free slot, or the held item leaves this cycle
   assign in_ready = ~valid_q | out_ready;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clk)
   begin
      if (rst | flush)
         valid_q <= 1'b0;
      else if (load)
         valid_q <= 1'b1;
      else if (out_ready)
         valid_q <= 1'b0;   // Drained
   end

   // Payload only moves on an accept
   always_ff @(posedge clk)
   begin
      if (load)
         data_q <= in_data;
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule : hds_pipe

`default_nettype wire

//--- verilog/uop_pkg.sv
//////////////////////////////
// Micro-op formats
// Issue, execute and write-back payloads, ALU opcodes
//////////////////////////////

`default_nettype none

package uop_pkg;
   import cpu_cfg_pkg::*;

   typedef logic [pc_w-1:0]     pc_t;
   typedef logic [data_w-1:0]   data_t;
   typedef logic [prf_aw-1:0]   preg_t;
   typedef logic [rob_id_w-1:0] rob_id_t;

   typedef enum logic [2:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_xor = 3'd4,
      alu_sll = 3'd5,   // Shift by low bits of operand 2
      alu_srl = 3'd6,
      alu_slt = 3'd7    // Signed compare
   } alu_op_e;

   // As handed over by the issuer
   typedef struct packed {
      pc_t     pc;
      alu_op_e alu_op;
      data_t   imm;
      preg_t   prs1;
      logic    prs1_re;   // Else operand 1 is imm
      preg_t   prs2;
      logic    prs2_re;   // Else operand 2 is imm
      preg_t   prd;
      logic    prd_we;
      rob_id_t rob_id;
   } issue_uop_t;

   // Operands resolved, ready for the ALU
   typedef struct packed {
      pc_t     pc;
      alu_op_e alu_op;
      data_t   operand1;
      data_t   operand2;
      preg_t   prd;
      logic    prd_we;
      rob_id_t rob_id;
   } ex_uop_t;

   typedef struct packed {
      pc_t     pc;
      data_t   result;
      preg_t   prd;
      logic    prd_we;
      rob_id_t rob_id;
   } wb_result_t;

endpackage : uop_pkg

`default_nettype wire

//--- verilog/cpu_cfg_pkg.sv
//////////////////////////////
// Backend configuration
// Lane count, datapath and register-file sizing
//////////////////////////////

`default_nettype none

package cpu_cfg_pkg;

   // Issue lanes
   localparam int lane_cnt = 2;

   // Datapath
   localparam int data_w  = 32;
   localparam int shamt_w = $clog2(data_w);   // Shift amount bits
   localparam int pc_w    = 30;               // Word address

   // Physical register file
   localparam int prf_aw    = 5;
   localparam int prf_depth = 1 << prf_aw;
   localparam int src_cnt   = 2;              // Source operands per micro-op
   localparam int rd_port_cnt = lane_cnt * src_cnt;

   // Reorder buffer tag, carried only
   localparam int rob_id_w = 4;

endpackage : cpu_cfg_pkg

`default_nettype wire
